// ==== dma_cmd_issue.sv ====
// Both queue heads must be valid together; the engine sees one request per command pair
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_cmd_issue import dma_pkg::*; (
   input  logic                       cmd_valid_i,
   input  dma_cmd_t                   cmd_i,
   input  logic                       addr_valid_i,
   input  dma_addr_t                  addr_i,
   output logic                       pop_o,
   output logic                       cmd_req_o,
   input  logic                       cmd_gnt_i,
   output logic [`DMA_SID_W-1:0]      cmd_sid_o,
   output logic [`DMA_LEN_W-1:0]      cmd_len_o,
   output logic [`DMA_OPC_W-1:0]      cmd_opc_o,
   output logic                       cmd_inc_o,
   output logic [`DMA_TCDM_ADD_W-1:0] tcdm_add_o,
   output logic [`DMA_EXT_ADD_W-1:0]  ext_add_o
);

   // ********************
   // Join of the two heads
   assign cmd_req_o = cmd_valid_i & addr_valid_i;

   // Both queues pop on the same handshake
   assign pop_o = cmd_req_o & cmd_gnt_i;

   // ********************
   // Unpack towards the engine
   assign cmd_sid_o  = cmd_i.sid;
   assign cmd_len_o  = cmd_i.len;
   assign cmd_opc_o  = cmd_i.opc;
   assign cmd_inc_o  = cmd_i.inc;
   assign tcdm_add_o = addr_i.tcdm_add;
   assign ext_add_o  = addr_i.ext_add;

endmodule

// ==== dma_consts.svh ====
// Sizes assume one PE per target and a power-of-two number of transfer ids
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// ********************
// Transfer ids and command fields
`define DMA_NB_TRANSFERS 4
`define DMA_SID_W        2
`define DMA_LEN_W        16
`define DMA_OPC_W        1
`define DMA_TCDM_ADD_W   12
`define DMA_EXT_ADD_W    29
`define DMA_QUEUE_DEPTH  2

// Bit positions of opc and inc in the command word, len sits at the bottom
`define DMA_CMD_OPC_BIT  16
`define DMA_CMD_INC_BIT  17

// ********************
// Register map, decoded on the low address bits only
`define DMA_REG_OFS_W    4
`define DMA_REG_CMD      4'h0
`define DMA_REG_TCDM     4'h4
`define DMA_REG_EXT      4'h8
`define DMA_REG_STATUS   4'hC

`endif

// ==== dma_core_if.sv ====
// One PE, 1D transfers only; done_sid_i must name a busy sid when done_valid_i is high
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_core_if import dma_pkg::*; (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic                         ctrl_req_i,
   input  logic                         ctrl_we_i,
   input  logic [31:0]                  ctrl_add_i,
   input  logic [31:0]                  ctrl_wdata_i,
   output logic                         ctrl_gnt_o,
   output logic                         ctrl_r_valid_o,
   output logic [31:0]                  ctrl_r_data_o,
   output logic                         cmd_req_o,
   input  logic                         cmd_gnt_i,
   output logic [`DMA_SID_W-1:0]        cmd_sid_o,
   output logic [`DMA_LEN_W-1:0]        cmd_len_o,
   output logic [`DMA_OPC_W-1:0]        cmd_opc_o,
   output logic                         cmd_inc_o,
   output logic [`DMA_TCDM_ADD_W-1:0]   tcdm_add_o,
   output logic [`DMA_EXT_ADD_W-1:0]    ext_add_o,
   input  logic                         done_valid_i,
   input  logic [`DMA_SID_W-1:0]        done_sid_i,
   output logic                         busy_o
);

   logic                         alloc_req;
   logic                         alloc_gnt;
   logic [`DMA_SID_W-1:0]        alloc_sid;
   logic [`DMA_NB_TRANSFERS-1:0] busy_mask;
   logic                         push_req;
   logic                         cmd_push_gnt;
   logic                         addr_push_gnt;
   dma_cmd_t                     push_cmd;
   dma_addr_t                    push_addr;
   logic                         cmd_valid;
   logic                         addr_valid;
   dma_cmd_t                     cmd_head;
   dma_addr_t                    addr_head;
   logic                         cmd_empty;
   logic                         addr_empty;
   logic                         pop;

   // ********************
   // Input side
   dma_reg_decoder i_reg_decoder (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .ctrl_req_i      (ctrl_req_i),
      .ctrl_we_i       (ctrl_we_i),
      .ctrl_add_i      (ctrl_add_i),
      .ctrl_wdata_i    (ctrl_wdata_i),
      .ctrl_gnt_o      (ctrl_gnt_o),
      .ctrl_r_valid_o  (ctrl_r_valid_o),
      .ctrl_r_data_o   (ctrl_r_data_o),
      .alloc_req_o     (alloc_req),
      .alloc_gnt_i     (alloc_gnt),
      .alloc_sid_i     (alloc_sid),
      .busy_mask_i     (busy_mask),
      .push_req_o      (push_req),
      .cmd_push_gnt_i  (cmd_push_gnt),
      .addr_push_gnt_i (addr_push_gnt),
      .push_cmd_o      (push_cmd),
      .push_addr_o     (push_addr)
   );

   dma_sid_alloc i_sid_alloc (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .alloc_req_i  (alloc_req),
      .alloc_gnt_o  (alloc_gnt),
      .alloc_sid_o  (alloc_sid),
      .done_valid_i (done_valid_i),
      .done_sid_i   (done_sid_i),
      .busy_mask_o  (busy_mask)
   );

   // ********************
   // Command and address queues
   dma_queue #(.payload_t(dma_cmd_t)) i_cmd_queue (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .push_req_i  (push_req),
      .push_gnt_o  (cmd_push_gnt),
      .push_dat_i  (push_cmd),
      .pop_req_i   (pop),
      .pop_valid_o (cmd_valid),
      .pop_dat_o   (cmd_head),
      .empty_o     (cmd_empty)
   );

   dma_queue #(.payload_t(dma_addr_t)) i_addr_queue (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .push_req_i  (push_req),
      .push_gnt_o  (addr_push_gnt),
      .push_dat_i  (push_addr),
      .pop_req_i   (pop),
      .pop_valid_o (addr_valid),
      .pop_dat_o   (addr_head),
      .empty_o     (addr_empty)
   );

   // ********************
   // Output side
   dma_cmd_issue i_cmd_issue (
      .cmd_valid_i  (cmd_valid),
      .cmd_i        (cmd_head),
      .addr_valid_i (addr_valid),
      .addr_i       (addr_head),
      .pop_o        (pop),
      .cmd_req_o    (cmd_req_o),
      .cmd_gnt_i    (cmd_gnt_i),
      .cmd_sid_o    (cmd_sid_o),
      .cmd_len_o    (cmd_len_o),
      .cmd_opc_o    (cmd_opc_o),
      .cmd_inc_o    (cmd_inc_o),
      .tcdm_add_o   (tcdm_add_o),
      .ext_add_o    (ext_add_o)
   );

   // Busy while a sid is out or a command is still queued
   assign busy_o = (|busy_mask) | ~cmd_empty | ~addr_empty;

endmodule

// ==== dma_pkg.sv ====
// Field order of the structs is fixed; the testbench packs and compares against it
`include "dma_consts.svh"

package dma_pkg;

   // ********************
   // One queued command
   // Opcode 0 moves ext to tcdm, 1 moves tcdm to ext
   typedef struct packed {
      logic [`DMA_SID_W-1:0] sid;
      logic [`DMA_LEN_W-1:0] len;
      logic [`DMA_OPC_W-1:0] opc;
      logic                  inc;
   } dma_cmd_t;

   // ********************
   // Address pair that travels next to the command
   typedef struct packed {
      logic [`DMA_TCDM_ADD_W-1:0] tcdm_add;
      logic [`DMA_EXT_ADD_W-1:0]  ext_add;
   } dma_addr_t;

   // Widths as seen by the ports, handy for checks
   localparam int dma_cmd_w  = $bits(dma_cmd_t);
   localparam int dma_addr_w = $bits(dma_addr_t);

endpackage

// ==== dma_queue.sv ====
// Depth comes from DMA_QUEUE_DEPTH; head data is only meaningful while pop_valid_o is high
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_queue #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     push_req_i,
   output logic     push_gnt_o,
   input  payload_t push_dat_i,
   input  logic     pop_req_i,
   output logic     pop_valid_o,
   output payload_t pop_dat_o,
   output logic     empty_o
);

   localparam int depth = `DMA_QUEUE_DEPTH;
   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);
   localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

   payload_t         mem_q [depth];
   logic [ptr_w-1:0] wr_ptr_q;
   logic [ptr_w-1:0] rd_ptr_q;
   logic [cnt_w-1:0] cnt_q;
   logic             push;
   logic             pop;

   assign push_gnt_o  = (cnt_q != cnt_w'(depth));
   assign empty_o     = (cnt_q == '0);
   assign pop_valid_o = ~empty_o;
   assign push        = push_req_i & push_gnt_o;
   assign pop         = pop_req_i & pop_valid_o;
   assign pop_dat_o   = mem_q[rd_ptr_q];

   // ********************
   // Pointers and fill count
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (push) wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + 1'b1;
         if (pop) rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + 1'b1;
         if (push && !pop) cnt_q <= cnt_q + 1'b1;
         else if (pop && !push) cnt_q <= cnt_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) mem_q[wr_ptr_q] <= push_dat_i;
   end

endmodule

// ==== dma_reg_decoder.sv ====
// Single PE target; only ctrl_add_i[3:0] is decoded, so the map mirrors over the upper bits
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_reg_decoder import dma_pkg::*; (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic                         ctrl_req_i,
   input  logic                         ctrl_we_i,
   input  logic [31:0]                  ctrl_add_i,
   input  logic [31:0]                  ctrl_wdata_i,
   output logic                         ctrl_gnt_o,
   output logic                         ctrl_r_valid_o,
   output logic [31:0]                  ctrl_r_data_o,
   output logic                         alloc_req_o,
   input  logic                         alloc_gnt_i,
   input  logic [`DMA_SID_W-1:0]        alloc_sid_i,
   input  logic [`DMA_NB_TRANSFERS-1:0] busy_mask_i,
   output logic                         push_req_o,
   input  logic                         cmd_push_gnt_i,
   input  logic                         addr_push_gnt_i,
   output dma_cmd_t                     push_cmd_o,
   output dma_addr_t                    push_addr_o
);

   logic [`DMA_REG_OFS_W-1:0]  ofs;
   logic                       sel_cmd;
   logic                       sel_tcdm;
   logic                       sel_ext;
   logic                       sel_status;
   logic                       acc;
   logic [31:0]                r_data_d;
   logic [31:0]                r_data_q;
   logic                       r_valid_q;
   logic [`DMA_SID_W-1:0]      sid_q;
   logic [`DMA_TCDM_ADD_W-1:0] tcdm_add_q;
   logic [`DMA_EXT_ADD_W-1:0]  ext_add_q;

   // ********************
   // Offset decode
   assign ofs        = ctrl_add_i[`DMA_REG_OFS_W-1:0];
   assign sel_cmd    = (ofs == `DMA_REG_CMD);
   assign sel_tcdm   = (ofs == `DMA_REG_TCDM);
   assign sel_ext    = (ofs == `DMA_REG_EXT);
   assign sel_status = (ofs == `DMA_REG_STATUS);

   // Command read asks for a sid, command write asks for a push
   assign alloc_req_o = ctrl_req_i & ~ctrl_we_i & sel_cmd;
   // Both queues must take the items together, so the push waits for both
   assign push_req_o  = ctrl_req_i & ctrl_we_i & sel_cmd & cmd_push_gnt_i & addr_push_gnt_i;

   always_comb begin
      ctrl_gnt_o = 1'b0;
      if (ctrl_req_i) begin
         if (sel_cmd) begin
            ctrl_gnt_o = ctrl_we_i ? (cmd_push_gnt_i & addr_push_gnt_i) : alloc_gnt_i;
         end else begin
            ctrl_gnt_o = 1'b1;
         end
      end
   end

   assign acc = ctrl_req_i & ctrl_gnt_o;

   // Read data, writes answer with zero
   always_comb begin
      r_data_d = '0;
      if (!ctrl_we_i) begin
         if (sel_cmd) r_data_d = 32'(alloc_sid_i);
         else if (sel_tcdm) r_data_d = 32'(tcdm_add_q);
         else if (sel_ext) r_data_d = 32'(ext_add_q);
         else if (sel_status) r_data_d = 32'(busy_mask_i);
      end
   end

   // ********************
   // Response and current sid
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_valid_q <= 1'b0;
         r_data_q  <= '0;
         sid_q     <= '0;
      end else begin
         r_valid_q <= acc;
         if (acc) r_data_q <= r_data_d;
         if (acc && !ctrl_we_i && sel_cmd) sid_q <= alloc_sid_i;
      end
   end

   // Address registers
   always_ff @(posedge clk_i) begin
      if (acc && ctrl_we_i && sel_tcdm) tcdm_add_q <= ctrl_wdata_i[`DMA_TCDM_ADD_W-1:0];
      if (acc && ctrl_we_i && sel_ext) ext_add_q <= ctrl_wdata_i[`DMA_EXT_ADD_W-1:0];
   end

   assign ctrl_r_valid_o = r_valid_q;
   assign ctrl_r_data_o  = r_data_q;

   // Command word fields plus the sid handed out last
   assign push_cmd_o.sid = sid_q;
   assign push_cmd_o.len = ctrl_wdata_i[`DMA_LEN_W-1:0];
   assign push_cmd_o.opc = ctrl_wdata_i[`DMA_CMD_OPC_BIT +: `DMA_OPC_W];
   assign push_cmd_o.inc = ctrl_wdata_i[`DMA_CMD_INC_BIT];

   assign push_addr_o.tcdm_add = tcdm_add_q;
   assign push_addr_o.ext_add  = ext_add_q;

endmodule

// ==== dma_sid_alloc.sv ====
// No grant in a cycle with a completion; the engine must only report sids that are busy
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_sid_alloc (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic                         alloc_req_i,
   output logic                         alloc_gnt_o,
   output logic [`DMA_SID_W-1:0]        alloc_sid_o,
   input  logic                         done_valid_i,
   input  logic [`DMA_SID_W-1:0]        done_sid_i,
   output logic [`DMA_NB_TRANSFERS-1:0] busy_mask_o
);

   logic [`DMA_NB_TRANSFERS-1:0] busy_q;
   logic [`DMA_NB_TRANSFERS-1:0] busy_d;
   logic                         any_free;

   // ********************
   // Lowest free index
   always_comb begin
      alloc_sid_o = '0;
      any_free    = 1'b0;
      for (int i = 0; i < `DMA_NB_TRANSFERS; i++) begin
         if (!busy_q[i] && !any_free) begin
            alloc_sid_o = `DMA_SID_W'(i);
            any_free    = 1'b1;
         end
      end
   end

   // Completion wins the cycle
   assign alloc_gnt_o = any_free & ~done_valid_i;

   always_comb begin
      busy_d = busy_q;
      if (done_valid_i) busy_d[done_sid_i] = 1'b0;
      if (alloc_req_i && alloc_gnt_o) busy_d[alloc_sid_o] = 1'b1;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q <= '0;
      end else begin
         busy_q <= busy_d;
      end
   end

   assign busy_mask_o = busy_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DMA core interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_dma_core_if -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_dma_core_if.sv ====
// Single PE target; the engine model only completes sids it has already received, LCG seed fixed
`timescale 1ns/1ps
`include "dma_consts.svh"

module tb_dma_core_if import dma_pkg::*; ();

   localparam logic [31:0] seed        = 32'h2275_7f79;
   localparam int          n_trans     = 200;
   localparam int          n_random    = 190;
   localparam int          cycle_limit = 40 * n_trans + 16;
   localparam logic [27:0] addr_base   = 28'h1020_040;

   logic                         clk_i = 1'b0;
   logic                         arst_n_i;
   logic                         ctrl_req_i;
   logic                         ctrl_we_i;
   logic [31:0]                  ctrl_add_i;
   logic [31:0]                  ctrl_wdata_i;
   logic                         ctrl_gnt_o;
   logic                         ctrl_r_valid_o;
   logic [31:0]                  ctrl_r_data_o;
   logic                         cmd_req_o;
   logic                         cmd_gnt_i;
   logic [`DMA_SID_W-1:0]        cmd_sid_o;
   logic [`DMA_LEN_W-1:0]        cmd_len_o;
   logic [`DMA_OPC_W-1:0]        cmd_opc_o;
   logic                         cmd_inc_o;
   logic [`DMA_TCDM_ADD_W-1:0]   tcdm_add_o;
   logic [`DMA_EXT_ADD_W-1:0]    ext_add_o;
   logic                         done_valid_i;
   logic [`DMA_SID_W-1:0]        done_sid_i;
   logic                         busy_o;

   // Reference model state
   logic [`DMA_NB_TRANSFERS-1:0] model_mask;
   logic [`DMA_NB_TRANSFERS-1:0] issued;
   logic [`DMA_SID_W-1:0]        model_sid;
   logic [`DMA_TCDM_ADD_W-1:0]   model_tcdm;
   logic [`DMA_EXT_ADD_W-1:0]    model_ext;
   dma_cmd_t                     exp_cmd_q[$];
   dma_addr_t                    exp_addr_q[$];
   logic [31:0]                  main_rnd;
   logic [31:0]                  eng_rnd;
   logic                         engine_hold;

   always #2 clk_i = ~clk_i;

   dma_core_if i_dut (.*);

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [`DMA_SID_W-1:0] lowest_free(input logic [`DMA_NB_TRANSFERS-1:0] mask);
      logic [`DMA_SID_W-1:0] sid;
      sid = '0;
      for (int i = `DMA_NB_TRANSFERS - 1; i >= 0; i--) begin
         if (!mask[i]) sid = `DMA_SID_W'(i);
      end
      return sid;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "Check failed");
   endtask

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (exp === act) else abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
   endtask

   // ********************
   // Control target accesses, model updated at the grant
   task automatic bus_access(input logic we, input logic [3:0] ofs, input logic [31:0] wdata,
                             input string name, output logic [31:0] rdata);
      logic [31:0] exp_rdata;
      dma_cmd_t    cmd;
      dma_addr_t   pair;
      @(negedge clk_i);
      ctrl_req_i   = 1'b1;
      ctrl_we_i    = we;
      ctrl_add_i   = {addr_base, ofs};
      ctrl_wdata_i = wdata;
      #1;
      while (!ctrl_gnt_o) begin
         assert (!ctrl_r_valid_o) else abort_run("Read response seen without a grant");
         @(negedge clk_i);
         #1;
      end
      exp_rdata = '0;
      if (we) begin
         case (ofs)
            `DMA_REG_TCDM: model_tcdm = wdata[`DMA_TCDM_ADD_W-1:0];
            `DMA_REG_EXT:  model_ext = wdata[`DMA_EXT_ADD_W-1:0];
            `DMA_REG_CMD: begin
               cmd.sid       = model_sid;
               cmd.len       = wdata[`DMA_LEN_W-1:0];
               cmd.opc       = wdata[`DMA_CMD_OPC_BIT +: `DMA_OPC_W];
               cmd.inc       = wdata[`DMA_CMD_INC_BIT];
               pair.tcdm_add = model_tcdm;
               pair.ext_add  = model_ext;
               exp_cmd_q.push_back(cmd);
               exp_addr_q.push_back(pair);
            end
            default: ;
         endcase
      end else begin
         case (ofs)
            `DMA_REG_CMD: begin
               assert (model_mask != '1) else abort_run("Command read granted with every sid busy");
               model_sid = lowest_free(model_mask);
               model_mask[model_sid] = 1'b1;
               exp_rdata = 32'(model_sid);
            end
            `DMA_REG_TCDM:   exp_rdata = 32'(model_tcdm);
            `DMA_REG_EXT:    exp_rdata = 32'(model_ext);
            `DMA_REG_STATUS: exp_rdata = 32'(model_mask);
            default: ;
         endcase
      end
      @(negedge clk_i);
      ctrl_req_i = 1'b0;
      #1;
      assert (ctrl_r_valid_o) else abort_run("No read response one cycle after the grant");
      rdata = ctrl_r_data_o;
      check_value(name, 64'(exp_rdata), 64'(rdata));
      // Busy while a sid is out or a command waits in the queues
      check_value({name, " busy"}, 64'((model_mask != '0) || (exp_cmd_q.size() != 0)),
                  64'(busy_o));
   endtask

   task automatic bus_read(input logic [3:0] ofs, input string name, output logic [31:0] rdata);
      bus_access(1'b0, ofs, 32'h0, name, rdata);
   endtask

   task automatic bus_write(input logic [3:0] ofs, input logic [31:0] data, input string name);
      logic [31:0] rdata;
      bus_access(1'b1, ofs, data, name, rdata);
   endtask

   task automatic write_addresses();
      logic [31:0] rdata;
      main_rnd = lcg(main_rnd);
      bus_write(`DMA_REG_TCDM, main_rnd, "write tcdm");
      main_rnd = lcg(main_rnd);
      bus_write(`DMA_REG_EXT, main_rnd, "write ext");
      bus_read(`DMA_REG_TCDM, "read tcdm", rdata);
      bus_read(`DMA_REG_EXT, "read ext", rdata);
      main_rnd = lcg(main_rnd);
   endtask

   // Sid, status, addresses, then the command word
   task automatic run_transfer();
      logic [31:0] rdata;
      bus_read(`DMA_REG_CMD, "read cmd sid", rdata);
      bus_read(`DMA_REG_STATUS, "read status", rdata);
      write_addresses();
      bus_write(`DMA_REG_CMD, main_rnd, "write cmd");
   endtask

   // Engine reports one random sid that it already took
   task automatic complete_one();
      logic [`DMA_SID_W-1:0] sid;
      while (issued == '0) @(negedge clk_i);
      do begin
         main_rnd = lcg(main_rnd);
         sid = main_rnd[31:30];
      end while (!issued[sid]);
      @(negedge clk_i);
      done_valid_i = 1'b1;
      done_sid_i   = sid;
      model_mask[sid] = 1'b0;
      issued[sid]     = 1'b0;
      @(negedge clk_i);
      done_valid_i = 1'b0;
   endtask

   // ********************
   // Engine side, random grant and in-order check
   task automatic run_engine();
      forever begin
         @(negedge clk_i);
         eng_rnd = lcg(eng_rnd);
         cmd_gnt_i = ~engine_hold & eng_rnd[20];
         #1;
         if (cmd_req_o && cmd_gnt_i) begin
            assert (exp_cmd_q.size() != 0) else abort_run("Engine request with no command pending");
            check_value("engine command", 64'({exp_cmd_q[0], exp_addr_q[0]}),
                        64'({cmd_sid_o, cmd_len_o, cmd_opc_o, cmd_inc_o, tcdm_add_o, ext_add_o}));
            issued[cmd_sid_o] = 1'b1;
            void'(exp_cmd_q.pop_front());
            void'(exp_addr_q.pop_front());
         end
      end
   endtask

   task automatic watch_cycles();
      int cycles;
      cycles = 0;
      forever begin
         @(posedge clk_i);
         cycles++;
         if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("TEST FAIL");
            $fatal(1, "Cycle limit reached");
         end
      end
   endtask

   initial begin
      logic [31:0] rdata;
      arst_n_i     = 1'b0;
      ctrl_req_i   = 1'b0;
      ctrl_we_i    = 1'b0;
      ctrl_add_i   = '0;
      ctrl_wdata_i = '0;
      cmd_gnt_i    = 1'b0;
      done_valid_i = 1'b0;
      done_sid_i   = '0;
      model_mask   = '0;
      issued       = '0;
      model_sid    = '0;
      main_rnd     = seed;
      eng_rnd      = ~seed;
      engine_hold  = 1'b0;
      fork
         watch_cycles();
         run_engine();
      join_none
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;
      #1;
      check_value("reset outputs", 64'h0, 64'({ctrl_gnt_o, ctrl_r_valid_o, cmd_req_o, busy_o}));
      bus_read(`DMA_REG_STATUS, "reset status", rdata);

      // ********************
      // Queues full, next command write must wait
      engine_hold = 1'b1;
      repeat (`DMA_QUEUE_DEPTH) run_transfer();
      bus_read(`DMA_REG_CMD, "read cmd sid", rdata);
      write_addresses();
      fork
         bus_write(`DMA_REG_CMD, main_rnd, "write cmd under back-pressure");
         begin
            repeat (8) begin
               @(negedge clk_i);
               #1;
               assert (!ctrl_gnt_o) else abort_run("Command write granted with both queues full");
            end
            engine_hold = 1'b0;
         end
      join
      while (exp_cmd_q.size() != 0) @(negedge clk_i);

      // ********************
      // Every sid busy, a completion frees one
      run_transfer();
      fork
         bus_read(`DMA_REG_CMD, "read cmd after completion", rdata);
         begin
            repeat (8) begin
               @(negedge clk_i);
               #1;
               assert (!ctrl_gnt_o) else abort_run("Command read granted with every sid busy");
            end
            complete_one();
         end
      join
      write_addresses();
      bus_write(`DMA_REG_CMD, main_rnd, "write cmd");

      for (int t = 0; t < n_random; t++) begin
         main_rnd = lcg(main_rnd);
         if (model_mask == '1 || main_rnd[29:28] == 2'b00) complete_one();
         run_transfer();
      end

      // Drain and release everything
      while (exp_cmd_q.size() != 0) @(negedge clk_i);
      while (issued != '0) complete_one();
      #1;
      check_value("busy after drain", 64'h0, 64'(busy_o));
      bus_read(`DMA_REG_STATUS, "status after drain", rdata);
      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+.
dma_pkg.sv
dma_reg_decoder.sv
dma_sid_alloc.sv
dma_queue.sv
dma_cmd_issue.sv
dma_core_if.sv
tb_dma_core_if.sv
